//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_rs_core and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f list.f \
		--top-module tb_rs_core -Mdir obj_dir -o sim_rs_core
	./obj_dir/sim_rs_core 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- list.f
+incdir+.
rs_pkg.sv
rs_entry_if.sv
rs_dispatch.sv
rs_slot.sv
rs_issue.sv
rs_core.sv
tb_rs_core.sv

//--- rs_core.sv
`include "rs_settings.svh"

module rs_core (
    input  logic                clk_in,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                disp_valid,
    output logic                disp_ready,
    input  rs_pkg::inst_op_e    disp_op,
    input  rs_pkg::reg_t        disp_rd,
    input  rs_pkg::reg_t        disp_rs1,
    input  rs_pkg::reg_t        disp_rs2,
    input  rs_pkg::word_t       disp_imm,
    input  rs_pkg::tag_t        disp_tag,
    input  logic                cdb_valid,
    input  rs_pkg::tag_t        cdb_tag,
    input  rs_pkg::word_t       cdb_value,
    output logic                done_valid,
    output rs_pkg::tag_t        done_tag,
    output rs_pkg::word_t       done_value
);

    // one link per entry, shared by dispatch, the entry itself and issue
    rs_entry_if ent [`RS_SIZE] ();

    // decode, rename and allocation into the lowest free entry
    rs_dispatch i_dispatch (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_op    (disp_op),
        .disp_rd    (disp_rd),
        .disp_rs1   (disp_rs1),
        .disp_rs2   (disp_rs2),
        .disp_imm   (disp_imm),
        .disp_tag   (disp_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .ent        (ent)
    );

    // every entry watches the same broadcast bus
    for (genvar g = 0; g < `RS_SIZE; g++) begin : g_slot
        rs_slot i_slot (
            .clk_in    (clk_in),
            .arst_n    (arst_n),
            .flush     (flush),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .cdb_value (cdb_value),
            .ent       (ent[g])
        );
    end

    // picks one ready entry per cycle and runs it through the ALU
    rs_issue i_issue (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .flush      (flush),
        .ent        (ent),
        .done_valid (done_valid),
        .done_tag   (done_tag),
        .done_value (done_value)
    );

endmodule

//--- rs_dispatch.sv
`include "rs_settings.svh"

module rs_dispatch (
    input  logic                clk_in,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                disp_valid,
    output logic                disp_ready,
    input  rs_pkg::inst_op_e    disp_op,
    input  rs_pkg::reg_t        disp_rd,
    input  rs_pkg::reg_t        disp_rs1,
    input  rs_pkg::reg_t        disp_rs2,
    input  rs_pkg::word_t       disp_imm,
    input  rs_pkg::tag_t        disp_tag,
    input  logic                cdb_valid,
    input  rs_pkg::tag_t        cdb_tag,
    input  rs_pkg::word_t       cdb_value,
    rs_entry_if.alloc           ent [`RS_SIZE]
);

    // architectural registers and the newest in-flight tag of each one
    rs_pkg::word_t              regs [1 << `REG_W];
    logic [(1 << `REG_W)-1:0]   ren_valid;
    rs_pkg::tag_t               ren_tag [1 << `REG_W];
    logic [(1 << `REG_W)-1:0]   wr_hit;

    logic [`RS_SIZE-1:0]        busy_vec;
    logic [`RS_SIZE-1:0]        load_vec;
    logic [`RS_IDX_W-1:0]       sel_idx;
    logic                       accept;

    rs_pkg::alu_op_e            dec_op;
    logic                       use_imm;
    logic                       zero_a;
    rs_pkg::reg_t               src [2];
    rs_pkg::word_t              src_val [2];
    logic                       src_rdy [2];
    rs_pkg::tag_t               src_tag [2];
    rs_pkg::entry_load_t        load_data;

    for (genvar i = 0; i < `RS_SIZE; i++) begin : g_ent
        assign busy_vec[i]       = ent[i].busy;
        assign ent[i].load       = load_vec[i];
        assign ent[i].load_data  = load_data;
    end

    // room is judged from registered busy bits only, so it never waits on disp_valid
    assign disp_ready = ~&busy_vec;
    // flush wins over a dispatch presented in the same cycle
    assign accept     = disp_valid && disp_ready && !flush;

    // scan from the top so the lowest empty entry is the one left in sel_idx
    always_comb begin
        sel_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                sel_idx = i[`RS_IDX_W-1:0];
            end
        end
        for (int i = 0; i < `RS_SIZE; i++) begin
            load_vec[i] = accept && (sel_idx == i[`RS_IDX_W-1:0]);
        end
    end

    // register and immediate forms share an ALU operation
    always_comb begin
        case (disp_op)
            rs_pkg::OP_SUB:                  dec_op = rs_pkg::ALU_SUB;
            rs_pkg::OP_AND, rs_pkg::OP_ANDI: dec_op = rs_pkg::ALU_AND;
            rs_pkg::OP_OR, rs_pkg::OP_ORI:   dec_op = rs_pkg::ALU_OR;
            rs_pkg::OP_XOR, rs_pkg::OP_XORI: dec_op = rs_pkg::ALU_XOR;
            rs_pkg::OP_SLL, rs_pkg::OP_SLLI: dec_op = rs_pkg::ALU_SLL;
            rs_pkg::OP_SRL, rs_pkg::OP_SRLI: dec_op = rs_pkg::ALU_SRL;
            rs_pkg::OP_SRA, rs_pkg::OP_SRAI: dec_op = rs_pkg::ALU_SRA;
            rs_pkg::OP_SLT, rs_pkg::OP_SLTI: dec_op = rs_pkg::ALU_SLT;
            rs_pkg::OP_SLTU, rs_pkg::OP_SLTIU: dec_op = rs_pkg::ALU_SLTU;
            default:                         dec_op = rs_pkg::ALU_ADD;
        endcase
    end

    // LUI becomes 0 + imm, the other immediate forms replace rs2 by imm
    assign zero_a  = (disp_op == rs_pkg::OP_LUI);
    assign use_imm = disp_op inside {rs_pkg::OP_ADDI, rs_pkg::OP_ANDI, rs_pkg::OP_ORI,
                                     rs_pkg::OP_XORI, rs_pkg::OP_SLLI, rs_pkg::OP_SRLI,
                                     rs_pkg::OP_SRAI, rs_pkg::OP_SLTI, rs_pkg::OP_SLTIU,
                                     rs_pkg::OP_LUI};

    assign src[0] = disp_rs1;
    assign src[1] = disp_rs2;

    // a broadcast of the current tag beats the rename table, which beats the register file
    // x0 is never renamed and holds zero from reset, so it always resolves to zero
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            src_tag[k] = ren_tag[src[k]];
            if (cdb_valid && ren_valid[src[k]] && ren_tag[src[k]] == cdb_tag) begin
                src_val[k] = cdb_value;
                src_rdy[k] = 1'b1;
            end else if (ren_valid[src[k]]) begin
                src_val[k] = regs[src[k]];
                src_rdy[k] = 1'b0;
            end else begin
                src_val[k] = regs[src[k]];
                src_rdy[k] = 1'b1;
            end
        end
    end

    always_comb begin
        load_data.alu_op  = dec_op;
        load_data.tag     = disp_tag;
        load_data.a_value = zero_a ? '0 : src_val[0];
        load_data.a_ready = zero_a || src_rdy[0];
        load_data.a_tag   = src_tag[0];
        load_data.b_value = use_imm ? disp_imm : src_val[1];
        load_data.b_ready = use_imm || src_rdy[1];
        load_data.b_tag   = src_tag[1];
    end

    // only the register whose newest mapping is the broadcast tag takes the value
    always_comb begin
        for (int r = 0; r < (1 << `REG_W); r++) begin
            wr_hit[r] = cdb_valid && ren_valid[r] && (ren_tag[r] == cdb_tag);
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            ren_valid <= '0;
            for (int r = 0; r < (1 << `REG_W); r++) begin
                regs[r] <= '0;
            end
        end else if (flush) begin
            // speculative mappings go away, committed values stay
            ren_valid <= '0;
        end else begin
            for (int r = 1; r < (1 << `REG_W); r++) begin
                if (wr_hit[r]) begin
                    regs[r]      <= cdb_value;
                    ren_valid[r] <= 1'b0;
                end
            end
            // a new mapping of the same register overrides the clear above
            if (accept && disp_rd != '0) begin
                ren_valid[disp_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept && disp_rd != '0) begin
            ren_tag[disp_rd] <= disp_tag;
        end
    end

    // the entry picked for an accepted instruction reports itself busy one cycle later
    a_accept_free: assert property (@(posedge clk_in) disable iff (!arst_n)
        accept |=> |($past(load_vec) & busy_vec));

endmodule

//--- rs_entry_if.sv
// one link between a reservation station entry and the units around it
// dispatch fills the entry, issue drains it
interface rs_entry_if;

    // allocation request and the instruction to be written
    logic                  load;
    rs_pkg::entry_load_t   load_data;

    // entry state as seen from outside
    logic                  busy;
    logic                  ready;

    // operands and identity of the held instruction
    rs_pkg::alu_op_e       alu_op;
    rs_pkg::word_t         opnd_a;
    rs_pkg::word_t         opnd_b;
    rs_pkg::tag_t          tag;

    // issue unit has picked this entry for the ALU this cycle
    logic                  grant;

    modport alloc (output load, output load_data, input busy);

    modport slot (input load, input load_data, input grant,
                  output busy, output ready, output alu_op,
                  output opnd_a, output opnd_b, output tag);

    modport issue (input ready, input alu_op, input opnd_a, input opnd_b,
                   input tag, output grant);

endinterface

//--- rs_issue.sv
`include "rs_settings.svh"

module rs_issue (
    input  logic            clk_in,
    input  logic            arst_n,
    input  logic            flush,
    rs_entry_if.issue       ent [`RS_SIZE],
    output logic            done_valid,
    output rs_pkg::tag_t    done_tag,
    output rs_pkg::word_t   done_value
);

    logic [`RS_SIZE-1:0]    rdy_vec;
    logic [`RS_SIZE-1:0]    grant_vec;
    logic [`RS_IDX_W-1:0]   gnt_idx;
    logic                   any_rdy;
    rs_pkg::alu_op_e        op_vec [`RS_SIZE];
    rs_pkg::word_t          a_vec [`RS_SIZE];
    rs_pkg::word_t          b_vec [`RS_SIZE];
    rs_pkg::tag_t           tag_vec [`RS_SIZE];

    // single-cycle integer ALU, shifts use only the low five bits of b
    function automatic rs_pkg::word_t alu_calc(input rs_pkg::alu_op_e op,
                                               input rs_pkg::word_t a,
                                               input rs_pkg::word_t b);
        case (op)
            rs_pkg::ALU_SUB:  alu_calc = a - b;
            rs_pkg::ALU_AND:  alu_calc = a & b;
            rs_pkg::ALU_OR:   alu_calc = a | b;
            rs_pkg::ALU_XOR:  alu_calc = a ^ b;
            rs_pkg::ALU_SLL:  alu_calc = a << b[4:0];
            rs_pkg::ALU_SRL:  alu_calc = a >> b[4:0];
            rs_pkg::ALU_SRA:  alu_calc = rs_pkg::word_t'($signed(a) >>> b[4:0]);
            rs_pkg::ALU_SLT:  alu_calc = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rs_pkg::ALU_SLTU: alu_calc = {{(`XLEN-1){1'b0}}, a < b};
            default:          alu_calc = a + b;
        endcase
    endfunction

    for (genvar i = 0; i < `RS_SIZE; i++) begin : g_ent
        assign rdy_vec[i]   = ent[i].ready;
        assign op_vec[i]    = ent[i].alu_op;
        assign a_vec[i]     = ent[i].opnd_a;
        assign b_vec[i]     = ent[i].opnd_b;
        assign tag_vec[i]   = ent[i].tag;
        assign ent[i].grant = grant_vec[i];
    end

    assign any_rdy = |rdy_vec;

    // fixed priority, the lowest-numbered ready entry goes first
    always_comb begin
        gnt_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (rdy_vec[i]) begin
                gnt_idx = i[`RS_IDX_W-1:0];
            end
        end
        for (int i = 0; i < `RS_SIZE; i++) begin
            grant_vec[i] = any_rdy && (gnt_idx == i[`RS_IDX_W-1:0]);
        end
    end

    // a grant in a flush cycle is dropped here as well as in the entry
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            done_valid <= 1'b0;
        end else begin
            done_valid <= any_rdy && !flush;
        end
    end

    // result and tag are registered together, one edge after the grant
    always_ff @(posedge clk_in) begin
        if (any_rdy) begin
            done_tag   <= tag_vec[gnt_idx];
            done_value <= alu_calc(op_vec[gnt_idx], a_vec[gnt_idx], b_vec[gnt_idx]);
        end
    end

endmodule

//--- rs_pkg.sv
`include "rs_settings.svh"

package rs_pkg;

    typedef logic [`XLEN-1:0]  word_t;
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`REG_W-1:0] reg_t;

    // decoded instruction opcodes as seen at the dispatch port
    // register forms first, then immediate forms, then LUI
    typedef enum logic [7:0] {
        OP_ADD = 8'h00, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_LUI
    } inst_op_e;

    // operations the single-cycle ALU can perform
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000, ALU_SUB = 4'b0001, ALU_AND = 4'b0010,
        ALU_OR = 4'b0011, ALU_XOR = 4'b0100, ALU_SLL = 4'b0101,
        ALU_SRL = 4'b0110, ALU_SRA = 4'b0111, ALU_SLT = 4'b1000,
        ALU_SLTU = 4'b1001
    } alu_op_e;

    // everything an entry takes in when it is allocated
    // an operand with its ready bit low waits for the broadcast of its tag
    typedef struct packed {
        alu_op_e alu_op;
        tag_t    tag;
        word_t   a_value;
        logic    a_ready;
        tag_t    a_tag;
        word_t   b_value;
        logic    b_ready;
        tag_t    b_tag;
    } entry_load_t;

endpackage

//--- rs_settings.svh
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// number of reservation station entries
`define RS_SIZE 4

// width of an entry index, log2 of RS_SIZE
`define RS_IDX_W 2

// reorder buffer tag width, sixteen tags in the tag space
`define TAG_W 4

// integer data path width
`define XLEN 32

// architectural register number width, 32 registers
`define REG_W 5

`endif

//--- rs_slot.sv
module rs_slot (
    input  logic            clk_in,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            cdb_valid,
    input  rs_pkg::tag_t    cdb_tag,
    input  rs_pkg::word_t   cdb_value,
    rs_entry_if.slot        ent
);

    logic               busy;
    logic               a_rdy;
    logic               b_rdy;
    logic               a_hit;
    logic               b_hit;
    rs_pkg::alu_op_e    alu_op;
    rs_pkg::tag_t       tag;
    rs_pkg::word_t      a_val;
    rs_pkg::word_t      b_val;
    rs_pkg::tag_t       a_tag;
    rs_pkg::tag_t       b_tag;

    // a waiting operand snoops the broadcast for the tag it was told to wait on
    assign a_hit = cdb_valid && busy && !a_rdy && (cdb_tag == a_tag);
    assign b_hit = cdb_valid && busy && !b_rdy && (cdb_tag == b_tag);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            a_rdy <= 1'b0;
            b_rdy <= 1'b0;
        end else if (flush) begin
            busy  <= 1'b0;
            a_rdy <= 1'b0;
            b_rdy <= 1'b0;
        end else if (ent.load) begin
            busy  <= 1'b1;
            a_rdy <= ent.load_data.a_ready;
            b_rdy <= ent.load_data.b_ready;
        end else begin
            // the entry leaves on the same edge that the issue unit takes it
            if (ent.grant) begin
                busy <= 1'b0;
            end
            if (a_hit) begin
                a_rdy <= 1'b1;
            end
            if (b_hit) begin
                b_rdy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (ent.load) begin
            alu_op <= ent.load_data.alu_op;
            tag    <= ent.load_data.tag;
            a_val  <= ent.load_data.a_value;
            a_tag  <= ent.load_data.a_tag;
            b_val  <= ent.load_data.b_value;
            b_tag  <= ent.load_data.b_tag;
        end else begin
            if (a_hit) begin
                a_val <= cdb_value;
            end
            if (b_hit) begin
                b_val <= cdb_value;
            end
        end
    end

    assign ent.busy   = busy;
    // ready only from held operands, so it shows one cycle after the last capture
    assign ent.ready  = busy && a_rdy && b_rdy;
    assign ent.alu_op = alu_op;
    assign ent.opnd_a = a_val;
    assign ent.opnd_b = b_val;
    assign ent.tag    = tag;

    // dispatch must never overwrite an instruction still in flight
    a_load_idle: assert property (@(posedge clk_in) disable iff (!arst_n)
        ent.load |-> !busy);

    // the issue unit only takes an entry whose operands are both present
    a_grant_ready: assert property (@(posedge clk_in) disable iff (!arst_n)
        ent.grant |-> (busy && a_rdy && b_rdy));

endmodule

//--- tb_rs_core.sv
`include "rs_settings.svh"

module tb_rs_core;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_TAGS       = 1 << `TAG_W;
    localparam int MAX_INFLIGHT = 8;
    localparam int N_OPS        = 20;
    localparam int N_RAND_A     = 60;
    localparam int N_RAND_B     = 40;
    // preload, every opcode, x0 probes, random, stall, flush batch, random
    localparam int N_INST = 7 + N_OPS + 3 + N_RAND_A + 5 + 5 + N_RAND_B;

    logic clk_in;
    logic arst_n;
    logic flush;
    logic disp_valid;
    logic disp_ready;
    rs_pkg::inst_op_e disp_op;
    rs_pkg::reg_t disp_rd;
    rs_pkg::reg_t disp_rs1;
    rs_pkg::reg_t disp_rs2;
    rs_pkg::word_t disp_imm;
    rs_pkg::tag_t disp_tag;
    logic cdb_valid = 1'b0;
    rs_pkg::tag_t cdb_tag = '0;
    rs_pkg::word_t cdb_value = '0;
    logic done_valid;
    rs_pkg::tag_t done_tag;
    rs_pkg::word_t done_value;

    integer seed = 8;
    int n_errors = 0;
    int n_checks = 0;
    int n_sent = 0;
    int n_done = 0;
    int n_dropped = 0;
    int inflight_cnt = 0;
    logic withhold = 1'b0;
    rs_pkg::tag_t next_tag = '0;
    // pending waits for a completion, inflight waits for its broadcast
    logic [N_TAGS-1:0] pending = '0;
    logic [N_TAGS-1:0] inflight = '0;
    rs_pkg::word_t exp_val [N_TAGS];
    rs_pkg::word_t model_regs [32];
    rs_pkg::word_t saved_regs [32];
    // completions the reorder buffer model has not broadcast yet
    rs_pkg::tag_t q_tag [$];
    rs_pkg::word_t q_val [$];

    rs_core i_rs_core (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_op    (disp_op),
        .disp_rd    (disp_rd),
        .disp_rs1   (disp_rs1),
        .disp_rs2   (disp_rs2),
        .disp_imm   (disp_imm),
        .disp_tag   (disp_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .done_valid (done_valid),
        .done_tag   (done_tag),
        .done_value (done_value)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // expected result of one instruction from the values its sources hold in program order
    function automatic rs_pkg::word_t ref_result(input rs_pkg::inst_op_e op,
                                                 input rs_pkg::word_t a,
                                                 input rs_pkg::word_t b,
                                                 input rs_pkg::word_t imm);
        rs_pkg::word_t y;
        case (op)
            rs_pkg::OP_ADD:   y = a + b;
            rs_pkg::OP_ADDI:  y = a + imm;
            rs_pkg::OP_SUB:   y = a - b;
            rs_pkg::OP_AND:   y = a & b;
            rs_pkg::OP_ANDI:  y = a & imm;
            rs_pkg::OP_OR:    y = a | b;
            rs_pkg::OP_ORI:   y = a | imm;
            rs_pkg::OP_XOR:   y = a ^ b;
            rs_pkg::OP_XORI:  y = a ^ imm;
            rs_pkg::OP_SLL:   y = a << b[4:0];
            rs_pkg::OP_SLLI:  y = a << imm[4:0];
            rs_pkg::OP_SRL:   y = a >> b[4:0];
            rs_pkg::OP_SRLI:  y = a >> imm[4:0];
            rs_pkg::OP_SRA:   y = $signed(a) >>> b[4:0];
            rs_pkg::OP_SRAI:  y = $signed(a) >>> imm[4:0];
            rs_pkg::OP_SLT:   y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rs_pkg::OP_SLTI:  y = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            rs_pkg::OP_SLTU:  y = (a < b) ? 32'd1 : 32'd0;
            rs_pkg::OP_SLTIU: y = (a < imm) ? 32'd1 : 32'd0;
            default:          y = imm;
        endcase
        return y;
    endfunction

    // registers x0 to x7 only, so that dependencies and x0 writes come often
    function automatic rs_pkg::reg_t pick_reg();
        return rs_pkg::reg_t'($unsigned($random(seed)) % 8);
    endfunction

    // LUI gets an upper immediate, the rest a sign-extended 12-bit one
    function automatic rs_pkg::word_t pick_imm(input rs_pkg::inst_op_e op);
        rs_pkg::word_t r;
        r = $random(seed);
        if (op == rs_pkg::OP_LUI) begin
            return {r[31:12], 12'h000};
        end
        return {{20{r[11]}}, r[11:0]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // called 1 unit after a rising edge, returns 1 unit after the accepting edge
    task automatic send_inst(input rs_pkg::inst_op_e op, input rs_pkg::reg_t rd,
                             input rs_pkg::reg_t rs1, input rs_pkg::reg_t rs2,
                             input rs_pkg::word_t imm);
        // a tag is reused only after its broadcast has been seen
        while (inflight_cnt >= MAX_INFLIGHT || inflight[next_tag]) begin
            @(posedge clk_in);
            #1;
        end
        exp_val[next_tag] = ref_result(op, model_regs[rs1], model_regs[rs2], imm);
        if (rd != '0) begin
            model_regs[rd] = exp_val[next_tag];
        end
        pending[next_tag]  = 1'b1;
        inflight[next_tag] = 1'b1;
        inflight_cnt++;
        disp_valid = 1'b1;
        disp_op    = op;
        disp_rd    = rd;
        disp_rs1   = rs1;
        disp_rs2   = rs2;
        disp_imm   = imm;
        disp_tag   = next_tag;
        // disp_ready only follows registered state, so mid-cycle it predicts the edge
        @(negedge clk_in);
        while (!disp_ready) begin
            @(negedge clk_in);
        end
        @(posedge clk_in);
        #1;
        disp_valid = 1'b0;
        next_tag   = next_tag + 1'b1;
        n_sent++;
    endtask

    task automatic send_random();
        rs_pkg::inst_op_e op;
        op = rs_pkg::inst_op_e'($unsigned($random(seed)) % N_OPS);
        send_inst(op, pick_reg(), pick_reg(), pick_reg(), pick_imm(op));
        repeat (int'($unsigned($random(seed)) % 3)) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    task automatic wait_drained();
        while (inflight_cnt != 0) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    // the reorder buffer model returns one recorded result now and then in random order
    always @(posedge clk_in) begin
        int pick;
        #1;
        cdb_valid = 1'b0;
        if (!withhold && q_tag.size() > 0 && ($random(seed) & 1)) begin
            pick = int'($unsigned($random(seed)) % q_tag.size());
            cdb_valid = 1'b1;
            cdb_tag   = q_tag[pick];
            cdb_value = q_val[pick];
            q_tag.delete(pick);
            q_val.delete(pick);
        end
    end

    // the compare process samples mid-cycle where completions and broadcasts are stable
    always @(negedge clk_in) begin
        if (arst_n && done_valid) begin
            if (!pending[done_tag]) begin
                n_errors++;
                $display("completion at time %0t for tag %0d, which has no instruction waiting",
                         $time, done_tag);
            end else begin
                check_val($sformatf("done_value[tag %0d]", done_tag), done_value,
                          exp_val[done_tag]);
                pending[done_tag] = 1'b0;
                n_done++;
                q_tag.push_back(done_tag);
                q_val.push_back(done_value);
            end
        end
        if (cdb_valid) begin
            inflight[cdb_tag] = 1'b0;
            inflight_cnt--;
        end
    end

    initial begin
        #((N_INST * 40 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the instructions did not all complete in the expected time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk_in     = 1'b0;
        arst_n     = 1'b0;
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp_op    = rs_pkg::OP_ADD;
        disp_rd    = '0;
        disp_rs1   = '0;
        disp_rs2   = '0;
        disp_imm   = '0;
        disp_tag   = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1;
        arst_n = 1'b1;
        @(negedge clk_in);
        check_val("done_valid", done_valid, 0);
        check_val("disp_ready", disp_ready, 1);
        @(posedge clk_in);
        #1;

        // fill x1 to x7 with full-width values
        for (int r = 1; r < 8; r++) begin
            send_inst(rs_pkg::OP_XORI, rs_pkg::reg_t'(r), '0, '0, $random(seed));
        end
        // every kept opcode once
        for (int i = 0; i < N_OPS; i++) begin
            send_inst(rs_pkg::inst_op_e'(i), pick_reg(), pick_reg(), pick_reg(),
                      pick_imm(rs_pkg::inst_op_e'(i)));
        end
        // a write to x0 must not show up in later reads of x0
        send_inst(rs_pkg::OP_ADDI, '0, 5'd1, '0, 32'h0000_0123);
        send_inst(rs_pkg::OP_OR, 5'd2, '0, '0, '0);
        send_inst(rs_pkg::OP_ADDI, 5'd3, '0, '0, 32'h0000_0007);
        repeat (N_RAND_A) send_random();

        // x5 is never broadcast, so four dependents fill every entry
        wait_drained();
        withhold = 1'b1;
        send_inst(rs_pkg::OP_ADDI, 5'd5, '0, '0, pick_imm(rs_pkg::OP_ADDI));
        repeat (4) send_inst(rs_pkg::OP_ADD, pick_reg(), 5'd5, pick_reg(), '0);
        @(negedge clk_in);
        check_val("disp_ready", disp_ready, 0);
        @(posedge clk_in);
        #1;
        withhold = 1'b0;

        // x6 is never broadcast, so its four dependents still fill every entry when flush comes
        wait_drained();
        saved_regs = model_regs;
        withhold = 1'b1;
        send_inst(rs_pkg::OP_ADDI, 5'd6, '0, '0, pick_imm(rs_pkg::OP_ADDI));
        repeat (4) send_inst(rs_pkg::OP_ADD, pick_reg(), 5'd6, pick_reg(), '0);
        repeat (3) begin
            @(posedge clk_in);
            #1;
        end
        flush = 1'b1;
        @(posedge clk_in);
        #1;
        flush = 1'b0;
        for (int t = 0; t < N_TAGS; t++) begin
            if (pending[t]) begin
                n_dropped++;
            end
        end
        pending      = '0;
        inflight     = '0;
        inflight_cnt = 0;
        q_tag.delete();
        q_val.delete();
        model_regs = saved_regs;
        withhold   = 1'b0;
        @(negedge clk_in);
        check_val("disp_ready", disp_ready, 1);
        check_val("done_valid", done_valid, 0);
        @(posedge clk_in);
        #1;
        repeat (N_RAND_B) send_random();

        wait_drained();
        repeat (10) @(posedge clk_in);
        if (pending != '0) begin
            n_errors++;
            $display("accepted instructions never completed, tags %b", pending);
        end
        if (n_done != n_sent - n_dropped) begin
            n_errors++;
            $display("%0d completions seen for %0d instructions that had to complete",
                     n_done, n_sent - n_dropped);
        end
        $display("sent %0d, completed %0d, flushed %0d, checks %0d, errors %0d",
                 n_sent, n_done, n_dropped, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
